// ==== source/vram_regs_consts.svh ====
// register numbers and fixed values for the vram register interface, include where needed
`ifndef VRAM_REGS_CONSTS_SVH
`define VRAM_REGS_CONSTS_SVH

// host register numbers
`define REG_SYS_CTRL    4'd0        // status bits and write mask
`define REG_TIMER       4'd2        // 1/10 ms tick counter

// vram port registers
`define REG_RD_INCR     4'd6        // added to rd addr after each read
`define REG_RD_ADDR     4'd7        // odd byte write starts a read
`define REG_WR_INCR     4'd8        // added to wr addr after each write
`define REG_WR_ADDR     4'd9        // vram write address
`define REG_DATA        4'd10       // write data in, read data out

// clocks per timer tick, 10 MHz / 10 kHz
`define TIMER_DIV       1000

// all nibbles enabled out of reset
`define WRMASK_RESET    4'hF

// SYS_CTRL bit that shows a vram access in flight
`define BUSY_BIT        15

`endif

// ==== source/vram_regs_pkg.sv ====
// shared data types for the vram register interface, imported by each block that needs them
package vram_regs_pkg;

    // host bus data byte
    typedef logic [7:0] byte_t;

    // register or vram data word
    typedef logic [15:0] word_t;

    // vram word address
    typedef logic [15:0] addr_t;

    // host register number
    typedef logic [3:0] reg_num_t;

    // nibble write enables, bit 3 is the top nibble
    typedef logic [3:0] wrmask_t;

    // vram request sequencer states
    typedef enum logic [1:0] {
        ACC_IDLE,   // waiting for a request
        ACC_READ,   // read in flight
        ACC_WRITE   // write in flight
    } access_state_t;

endpackage

// ==== source/bus_sync.sv ====
// synchronizes the async host bus and turns a chip select fall into one read or write strobe
`timescale 1ns/100ps

module bus_sync (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     bus_cs_n_i,      // chip select, active low
    input  logic                     bus_rd_nwr_i,    // 1 = read
    input  logic                     bus_bytesel_i,   // 0 = even (high) byte
    input  vram_regs_pkg::reg_num_t  bus_reg_num_i,
    input  vram_regs_pkg::byte_t     bus_data_i,
    output logic                     write_strobe_o,  // one clock per write access
    output logic                     read_strobe_o,   // one clock per read access
    output logic                     bytesel_o,
    output vram_regs_pkg::reg_num_t  reg_num_o,
    output vram_regs_pkg::byte_t     data_o
);

    import vram_regs_pkg::*;

    logic cs_meta;      // first sync stage
    logic cs_sync;      // second sync stage
    logic cs_prev;      // delayed copy for edge detect
    logic cs_fall;      // chip select just went low

    assign cs_fall = cs_prev & ~cs_sync;  // high to low seen on synced cs

    // two flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_meta <= 1'b1;    // bus idle
            cs_sync <= 1'b1;
            cs_prev <= 1'b1;
        end else begin
            cs_meta <= bus_cs_n_i;
            cs_sync <= cs_meta;
            cs_prev <= cs_sync;
        end
    end

    // strobes and held access fields
    always_ff @(posedge clk) begin
        if (reset_i) begin
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            bytesel_o      <= 1'b0;
            reg_num_o      <= '0;
        end else begin
            write_strobe_o <= cs_fall & ~bus_rd_nwr_i;
            read_strobe_o  <= cs_fall & bus_rd_nwr_i;
            if (cs_fall) begin
                bytesel_o <= bus_bytesel_i;   // host holds these while cs low
                reg_num_o <= bus_reg_num_i;
            end
        end
    end

    // write byte, only meaningful with write strobe
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            data_o <= bus_data_i;
        end
    end

endmodule

// ==== source/tick_timer.sv ====
// free running 1/10 ms tick counter with a low byte latch for consistent two byte reads
`timescale 1ns/100ps

`include "vram_regs_consts.svh"

module tick_timer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  latch_i,        // high byte being read
    output vram_regs_pkg::word_t  timer_o,        // live tick count
    output vram_regs_pkg::byte_t  latch_byte_o    // low byte held at latch time
);

    import vram_regs_pkg::*;

    localparam int DIV_W = $clog2(`TIMER_DIV);

    logic [DIV_W-1:0] div_cnt;   // clocks within current tick
    logic             tick;      // last clock of a tick

    assign tick = (div_cnt == DIV_W'(`TIMER_DIV - 1));

    // divider and tick count
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_cnt <= '0;
            timer_o <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            timer_o <= timer_o + 16'd1;   // wraps after 6.5 s
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // low byte snapshot
    always_ff @(posedge clk) begin
        if (reset_i) begin
            latch_byte_o <= '0;
        end else if (latch_i) begin
            latch_byte_o <= timer_o[7:0];
        end
    end

endmodule

// ==== source/vram_access.sv ====
// sequences one vram read or write at a time, holding the request until the vram acknowledges
`timescale 1ns/100ps

module vram_access (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    rd_req_i,       // read request strobe
    input  logic                    wr_req_i,       // write request strobe
    input  vram_regs_pkg::addr_t    req_addr_i,
    input  vram_regs_pkg::word_t    req_data_i,     // write data
    input  vram_regs_pkg::wrmask_t  wrmask_i,
    input  logic                    vram_ack_i,     // access complete
    input  vram_regs_pkg::word_t    vram_data_i,    // valid with ack
    output logic                    vram_sel_o,
    output logic                    vram_wr_o,
    output vram_regs_pkg::addr_t    vram_addr_o,
    output vram_regs_pkg::word_t    vram_data_o,
    output vram_regs_pkg::wrmask_t  vram_wrmask_o,
    output logic                    rd_done_o,      // read data ready
    output logic                    wr_done_o,      // write finished
    output vram_regs_pkg::word_t    rd_data_o,
    output logic                    busy_o
);

    import vram_regs_pkg::*;

    access_state_t state;
    logic          accept;   // new request taken this clock

    assign accept = (state == ACC_IDLE) & (rd_req_i | wr_req_i);  // dropped when busy
    assign busy_o = (state != ACC_IDLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= ACC_IDLE;
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            rd_done_o  <= 1'b0;
            wr_done_o  <= 1'b0;
        end else begin
            rd_done_o <= 1'b0;
            wr_done_o <= 1'b0;
            case (state)
                ACC_IDLE: begin
                    if (wr_req_i) begin           // write wins if both arrive
                        state      <= ACC_WRITE;
                        vram_sel_o <= 1'b1;
                        vram_wr_o  <= 1'b1;
                    end else if (rd_req_i) begin
                        state      <= ACC_READ;
                        vram_sel_o <= 1'b1;
                        vram_wr_o  <= 1'b0;
                    end
                end
                ACC_READ: begin
                    if (vram_ack_i) begin
                        state      <= ACC_IDLE;
                        vram_sel_o <= 1'b0;
                        rd_done_o  <= 1'b1;
                    end
                end
                ACC_WRITE: begin
                    if (vram_ack_i) begin
                        state      <= ACC_IDLE;
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        wr_done_o  <= 1'b1;
                    end
                end
                default: state <= ACC_IDLE;
            endcase
        end
    end

    // request fields and returned data
    always_ff @(posedge clk) begin
        if (accept) begin
            vram_addr_o   <= req_addr_i;
            vram_data_o   <= req_data_i;
            vram_wrmask_o <= wrmask_i;
        end
        if ((state == ACC_READ) && vram_ack_i) begin
            rd_data_o <= vram_data_i;   // held until next read
        end
    end

endmodule

// ==== source/reg_file.sv ====
// host visible registers, byte write decode, read mux and vram address auto increment
`timescale 1ns/100ps

`include "vram_regs_consts.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     write_strobe_i,
    input  logic                     read_strobe_i,
    input  logic                     bytesel_i,       // 0 = even (high) byte
    input  vram_regs_pkg::reg_num_t  reg_num_i,
    input  vram_regs_pkg::byte_t     wr_byte_i,
    output vram_regs_pkg::byte_t     rd_byte_o,       // selected byte of addressed reg
    input  vram_regs_pkg::word_t     timer_i,
    input  vram_regs_pkg::byte_t     latch_byte_i,
    output logic                     timer_latch_o,   // snapshot timer low byte
    input  logic                     busy_i,
    input  logic                     rd_done_i,
    input  logic                     wr_done_i,
    input  vram_regs_pkg::word_t     rd_data_i,
    output logic                     rd_req_o,
    output logic                     wr_req_o,
    output vram_regs_pkg::addr_t     req_addr_o,
    output vram_regs_pkg::word_t     req_data_o,
    output vram_regs_pkg::wrmask_t   wrmask_o
);

    import vram_regs_pkg::*;

    word_t rd_incr;      // RD_INCR
    addr_t rd_addr;      // RD_ADDR
    word_t wr_incr;      // WR_INCR
    addr_t wr_addr;      // WR_ADDR
    byte_t data_even;    // DATA high byte waiting for odd byte
    word_t rd_word;      // last word read from vram
    word_t sys_word;     // SYS_CTRL read value
    word_t rd_mux;       // addressed register
    logic  mem_busy;     // request anywhere between here and done

    // covers the request and done clocks around the sequencer busy
    assign mem_busy = busy_i | rd_req_o | wr_req_o | rd_done_i | wr_done_i;

    // only a high byte read of TIMER freezes the low byte
    assign timer_latch_o = read_strobe_i & ~bytesel_i & (reg_num_i == `REG_TIMER);

    always_comb begin
        sys_word            = '0;
        sys_word[`BUSY_BIT] = mem_busy;
        sys_word[3:0]       = wrmask_o;
    end

    always_comb begin
        case (reg_num_i)
            `REG_SYS_CTRL: rd_mux = sys_word;
            `REG_TIMER:    rd_mux = {timer_i[15:8], latch_byte_i};   // live high, latched low
            `REG_RD_INCR:  rd_mux = rd_incr;
            `REG_RD_ADDR:  rd_mux = rd_addr;
            `REG_WR_INCR:  rd_mux = wr_incr;
            `REG_WR_ADDR:  rd_mux = wr_addr;
            `REG_DATA:     rd_mux = rd_word;
            default:       rd_mux = '0;   // unused numbers read zero
        endcase
    end

    assign rd_byte_o = bytesel_i ? rd_mux[7:0] : rd_mux[15:8];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_incr  <= '0;
            rd_addr  <= '0;
            wr_incr  <= '0;
            wr_addr  <= '0;
            wrmask_o <= `WRMASK_RESET;
            rd_req_o <= 1'b0;
            wr_req_o <= 1'b0;
        end else begin
            rd_req_o <= 1'b0;
            wr_req_o <= 1'b0;

            // step addresses when the access completes
            if (rd_done_i) begin
                rd_addr <= rd_addr + rd_incr;
            end
            if (wr_done_i) begin
                wr_addr <= wr_addr + wr_incr;
            end

            if (write_strobe_i) begin
                case (reg_num_i)
                    `REG_SYS_CTRL: begin
                        if (bytesel_i) begin
                            wrmask_o <= wr_byte_i[3:0];   // even byte has no writable bits
                        end
                    end
                    `REG_RD_INCR: begin
                        if (!bytesel_i) rd_incr[15:8] <= wr_byte_i;
                        else            rd_incr[7:0]  <= wr_byte_i;
                    end
                    `REG_RD_ADDR: begin
                        if (!bytesel_i) begin
                            rd_addr[15:8] <= wr_byte_i;
                        end else begin
                            rd_addr[7:0] <= wr_byte_i;
                            rd_req_o     <= 1'b1;                          // read new address
                            req_addr_o   <= {rd_addr[15:8], wr_byte_i};
                        end
                    end
                    `REG_WR_INCR: begin
                        if (!bytesel_i) wr_incr[15:8] <= wr_byte_i;
                        else            wr_incr[7:0]  <= wr_byte_i;
                    end
                    `REG_WR_ADDR: begin
                        if (!bytesel_i) wr_addr[15:8] <= wr_byte_i;
                        else            wr_addr[7:0]  <= wr_byte_i;
                    end
                    `REG_DATA: begin
                        if (bytesel_i) begin
                            wr_req_o   <= 1'b1;                            // odd byte commits
                            req_addr_o <= wr_addr;
                            req_data_o <= {data_even, wr_byte_i};
                        end
                    end
                    default: ;
                endcase
            end

            // odd byte read of DATA fetches the next word
            if (read_strobe_i && bytesel_i && (reg_num_i == `REG_DATA)) begin
                rd_req_o   <= 1'b1;
                req_addr_o <= rd_addr;
            end
        end
    end

    // held DATA even byte and last returned word
    always_ff @(posedge clk) begin
        if (write_strobe_i && !bytesel_i && (reg_num_i == `REG_DATA)) begin
            data_even <= wr_byte_i;
        end
        if (rd_done_i) begin
            rd_word <= rd_data_i;
        end
    end

endmodule

// ==== source/vram_reg_top.sv ====
// top level of the host register interface, connects bus sync, registers, timer and vram sequencer
`timescale 1ns/100ps

module vram_reg_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     bus_cs_n_i,      // host chip select, active low
    input  logic                     bus_rd_nwr_i,    // 1 = read
    input  vram_regs_pkg::reg_num_t  bus_reg_num_i,
    input  logic                     bus_bytesel_i,   // 0 = even (high) byte
    input  vram_regs_pkg::byte_t     bus_data_i,
    output vram_regs_pkg::byte_t     bus_data_o,
    input  logic                     vram_ack_i,
    input  vram_regs_pkg::word_t     vram_data_i,
    output logic                     vram_sel_o,
    output logic                     vram_wr_o,
    output vram_regs_pkg::addr_t     vram_addr_o,
    output vram_regs_pkg::word_t     vram_data_o,
    output vram_regs_pkg::wrmask_t   vram_wrmask_o
);

    import vram_regs_pkg::*;

    logic     write_strobe, read_strobe, bytesel;   // bus_sync to reg_file
    reg_num_t reg_num;
    byte_t    wr_byte;
    word_t    timer;                                // timer to reg_file
    byte_t    latch_byte;
    logic     timer_latch;
    logic     rd_req, wr_req;                       // reg_file to vram_access
    addr_t    req_addr;
    word_t    req_data;
    wrmask_t  wrmask;
    logic     rd_done, wr_done, busy;               // vram_access back to reg_file
    word_t    rd_data;

    bus_sync u_bus_sync (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_bytesel_i(bus_bytesel_i), .bus_reg_num_i(bus_reg_num_i), .bus_data_i(bus_data_i),
        .write_strobe_o(write_strobe), .read_strobe_o(read_strobe),
        .bytesel_o(bytesel), .reg_num_o(reg_num), .data_o(wr_byte)
    );

    tick_timer u_tick_timer (
        .clk(clk), .reset_i(reset_i),
        .latch_i(timer_latch), .timer_o(timer), .latch_byte_o(latch_byte)
    );

    reg_file u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .write_strobe_i(write_strobe), .read_strobe_i(read_strobe), .bytesel_i(bytesel),
        .reg_num_i(reg_num), .wr_byte_i(wr_byte), .rd_byte_o(bus_data_o),
        .timer_i(timer), .latch_byte_i(latch_byte), .timer_latch_o(timer_latch),
        .busy_i(busy), .rd_done_i(rd_done), .wr_done_i(wr_done), .rd_data_i(rd_data),
        .rd_req_o(rd_req), .wr_req_o(wr_req), .req_addr_o(req_addr),
        .req_data_o(req_data), .wrmask_o(wrmask)
    );

    vram_access u_vram_access (
        .clk(clk), .reset_i(reset_i),
        .rd_req_i(rd_req), .wr_req_i(wr_req), .req_addr_i(req_addr),
        .req_data_i(req_data), .wrmask_i(wrmask),
        .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .vram_wrmask_o(vram_wrmask_o),
        .rd_done_o(rd_done), .wr_done_o(wr_done), .rd_data_o(rd_data), .busy_o(busy)
    );

endmodule

// ==== tb/vram_model.sv ====
// behavioural 64K word vram for simulation, acks 3 clocks after select and merges writes by nibble
`timescale 1ns/100ps

module vram_model (
    input  logic                    clk,
    input  logic                    sel_i,       // access request
    input  logic                    wr_i,        // 1 = write
    input  vram_regs_pkg::addr_t    addr_i,
    input  vram_regs_pkg::word_t    data_i,      // write data
    input  vram_regs_pkg::wrmask_t  wrmask_i,    // bit 3 = top nibble
    output logic                    ack_o,       // one clock, ends the access
    output vram_regs_pkg::word_t    data_o       // read data, valid with ack
);

    import vram_regs_pkg::*;

    word_t      mem [0:65535];
    logic [1:0] wait_cnt;    // clocks since select seen

    // replace only the enabled nibbles
    function automatic word_t merge_nibbles(word_t old_word, word_t new_word, wrmask_t mask);
        word_t merged;
        merged = old_word;
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) merged[4*k +: 4] = new_word[4*k +: 4];
        end
        return merged;
    endfunction

    initial begin
        ack_o    = 1'b0;
        data_o   = '0;
        wait_cnt = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = word_t'(i * 40503) ^ 16'h5a5a;   // odd multiplier, every address bit counts
        end
    end

    always @(posedge clk) begin
        if (!sel_i || ack_o) begin
            ack_o    <= 1'b0;   // sel drops in the clock that sees ack
            wait_cnt <= '0;
        end else if (wait_cnt == 2'd2) begin
            ack_o <= 1'b1;
            if (wr_i) mem[addr_i] <= merge_nibbles(mem[addr_i], data_i, wrmask_i);
            else      data_o      <= mem[addr_i];
        end else begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

endmodule

// ==== tb/tb_vram_regs.sv ====
// directed testbench for the vram register interface, run with the sim.f file list
`timescale 1ns/100ps

`include "vram_regs_consts.svh"

module tb_vram_regs;

    import vram_regs_pkg::*;

    localparam int CLK_PERIOD = 100;   // 10 MHz
    localparam int DRIVE_DLY  = 10;    // input change after rising edge
    localparam int MAX_POLLS  = 50;    // SYS_CTRL reads before giving up
    localparam int N_WORDS    = 6;     // words per port test

    logic     clk;
    logic     reset_i;
    logic     bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    reg_num_t bus_reg_num_i;
    byte_t    bus_data_i, bus_data_o;
    logic     vram_ack_i, vram_sel_o, vram_wr_o;
    word_t    vram_data_i, vram_data_o;
    addr_t    vram_addr_o;
    wrmask_t  vram_wrmask_o;
    integer   seed;                    // shared $random state

    vram_reg_top uut (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
        .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .vram_wrmask_o(vram_wrmask_o)
    );

    vram_model u_vram (
        .clk(clk), .sel_i(vram_sel_o), .wr_i(vram_wr_o), .addr_i(vram_addr_o),
        .data_i(vram_data_o), .wrmask_i(vram_wrmask_o),
        .ack_o(vram_ack_i), .data_o(vram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s expected %h, actual %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s expected %h, actual %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s expected %b, actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;   // land just after the edge
    endtask

    // one host access, cs low 6 clocks then high 4 so the next fall is seen
    task automatic bus_write(input reg_num_t num, input logic odd, input byte_t data);
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_data_i    = data;
        bus_rd_nwr_i  = 1'b0;
        bus_cs_n_i    = 1'b0;
        wait_cycles(6);
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        wait_cycles(4);
    endtask

    task automatic bus_read(input reg_num_t num, input logic odd, output byte_t data);
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_rd_nwr_i  = 1'b1;
        bus_cs_n_i    = 1'b0;
        wait_cycles(6);
        data          = bus_data_o;   // reg captured 3 clocks in, mux settled
        bus_cs_n_i    = 1'b1;
        wait_cycles(4);
    endtask

    // even byte is the high byte and goes first
    task automatic write_word(input reg_num_t num, input word_t value);
        bus_write(num, 1'b0, value[15:8]);
        bus_write(num, 1'b1, value[7:0]);
    endtask

    task automatic read_word(input reg_num_t num, output word_t value);
        byte_t hi;
        byte_t lo;
        bus_read(num, 1'b0, hi);
        bus_read(num, 1'b1, lo);
        value = {hi, lo};
    endtask

    task automatic poll_idle;
        byte_t status;
        int    polls;
        polls = 0;
        bus_read(`REG_SYS_CTRL, 1'b0, status);
        while (status[`BUSY_BIT - 8]) begin   // busy sits in the high byte
            polls++;
            if (polls > MAX_POLLS) report_failure("timeout: busy bit never cleared");
            bus_read(`REG_SYS_CTRL, 1'b0, status);
        end
    endtask

    task automatic reset_defaults;
        byte_t b;
        word_t w;
        compare_bit("vram_sel_o", 1'b0, vram_sel_o);     // no access in flight
        compare_bit("vram_wr_o", 1'b0, vram_wr_o);
        bus_read(`REG_SYS_CTRL, 1'b0, b);
        compare_byte("SYS_CTRL high byte", 8'h00, b);    // busy clear
        bus_read(`REG_SYS_CTRL, 1'b1, b);
        compare_byte("SYS_CTRL low byte", {4'h0, `WRMASK_RESET}, b);
        read_word(`REG_WR_ADDR, w);
        compare_word("WR_ADDR", 16'h0000, w);
        read_word(`REG_RD_INCR, w);
        compare_word("RD_INCR", 16'h0000, w);
    endtask

    task automatic register_round_trip;
        word_t v_rd_incr, v_wr_incr, v_wr_addr, w;
        v_rd_incr = $random(seed);
        v_wr_incr = $random(seed);
        v_wr_addr = $random(seed);
        write_word(`REG_RD_INCR, v_rd_incr);
        write_word(`REG_WR_INCR, v_wr_incr);
        write_word(`REG_WR_ADDR, v_wr_addr);
        read_word(`REG_RD_INCR, w);
        compare_word("RD_INCR", v_rd_incr, w);
        read_word(`REG_WR_INCR, w);
        compare_word("WR_INCR", v_wr_incr, w);
        read_word(`REG_WR_ADDR, w);
        compare_word("WR_ADDR", v_wr_addr, w);
    endtask

    task automatic sequential_writes;
        word_t words [N_WORDS];
        addr_t base;
        word_t w;
        base = $random(seed);
        write_word(`REG_WR_ADDR, base);
        write_word(`REG_WR_INCR, 16'h0001);
        for (int i = 0; i < N_WORDS; i++) begin
            words[i] = $random(seed);
            write_word(`REG_DATA, words[i]);   // odd byte starts the write
            poll_idle();
        end
        for (int i = 0; i < N_WORDS; i++) begin
            compare_word("vram word", words[i], u_vram.mem[addr_t'(base + i)]);
        end
        read_word(`REG_WR_ADDR, w);
        compare_word("WR_ADDR", addr_t'(base + N_WORDS), w);
    endtask

    task automatic prefetched_reads;
        addr_t base;
        word_t w;
        base = $random(seed);
        write_word(`REG_RD_INCR, 16'h0001);
        write_word(`REG_RD_ADDR, base);    // odd byte fetches base
        poll_idle();
        for (int i = 0; i < N_WORDS; i++) begin
            read_word(`REG_DATA, w);       // odd byte read prefetches next
            poll_idle();
            compare_word("DATA", u_vram.mem[addr_t'(base + i)], w);
        end
        read_word(`REG_RD_ADDR, w);
        compare_word("RD_ADDR", addr_t'(base + N_WORDS + 1), w);
    endtask

    task automatic masked_write;
        byte_t b;
        byte_t low_flip;
        addr_t target;
        word_t old_word, new_word;
        bus_write(`REG_SYS_CTRL, 1'b1, 8'h03);   // low two nibbles only
        bus_read(`REG_SYS_CTRL, 1'b1, b);
        compare_byte("SYS_CTRL low byte", 8'h03, b);
        read_word(`REG_WR_ADDR, target);
        old_word = u_vram.mem[target];
        low_flip = $random(seed);
        new_word = old_word ^ {8'hff, low_flip | 8'h11};   // every nibble differs from old
        write_word(`REG_DATA, new_word);
        poll_idle();
        compare_word("vram masked word", {old_word[15:8], new_word[7:0]}, u_vram.mem[target]);
        bus_write(`REG_SYS_CTRL, 1'b1, {4'h0, `WRMASK_RESET});
    endtask

    task automatic timer_rate;
        word_t t_first, t_second, ticks;
        time   start_ns, end_ns;
        int    elapsed;
        start_ns = $time;
        read_word(`REG_TIMER, t_first);    // high read latches the low byte
        wait_cycles(3 * `TIMER_DIV);
        end_ns = $time;
        read_word(`REG_TIMER, t_second);
        elapsed = int'((end_ns - start_ns) / CLK_PERIOD);
        ticks   = t_second - t_first;
        if (ticks < 16'd3) begin
            report_failure($sformatf("timer advanced only %0d ticks in %0d clocks",
                                     ticks, elapsed));
        end
        if (ticks > word_t'(elapsed / `TIMER_DIV + 1)) begin
            report_failure($sformatf("timer advanced %0d ticks in only %0d clocks",
                                     ticks, elapsed));
        end
    endtask

    initial begin
        seed          = 32'hefcd75e1;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;          // bus idle
        bus_rd_nwr_i  = 1'b1;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = '0;
        bus_data_i    = '0;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;
        wait_cycles(4);

        reset_defaults();
        register_round_trip();
        sequential_writes();
        prefetched_reads();
        masked_write();
        timer_rate();

        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/vram_regs_pkg.sv
source/bus_sync.sv
source/tick_timer.sv
source/vram_access.sv
source/reg_file.sv
source/vram_reg_top.sv
tb/vram_model.sv
tb/tb_vram_regs.sv
